/* files.f */
source/core_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/operand_stage.sv
source/execute_stage.sv
source/writeback_stage.sv
source/core_top.sv
testbench/core_tb.sv

/* Makefile */
# Verilator build for the pipelined core and its testbench

VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --timing --assert --timescale 1ns/100ps
SIM_ARGS  ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)

# exit status of the simulator is the pass or fail result
sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

/* testbench/core_tb.sv */
`timescale 1ns/100ps

module core_tb
   import core_pkg::*;
();

   localparam int PROG_LEN = 24;
   // fall-through word of the last jump
   localparam int SLOW_WORD = 20;

   typedef struct packed {
      word_t addr;
      word_t data;
   } store_t;

   logic    clk = 1'b0;
   logic    rst_n;
   logic    imem_valid;
   logic    imem_ready;
   word_t   imem_addr;
   logic    imem_rvalid;
   logic    imem_rready;
   word_t   imem_rdata;
   logic    wmem_valid;
   logic    wmem_ready;
   word_t   wmem_addr;
   word_t   wmem_data;
   logic    commit_valid;
   commit_t commit;

   word_t   prog [PROG_LEN];
   commit_t exp_commits [$];
   store_t  exp_stores [$];
   integer  seed = 32'h5c70_bf52;
   int      cycles = 0;
   int      cycle_limit = 0;

   core_top #(
      .RESET_PC (RESET_PC),
      .NUM_REGS (NUM_REGS)
   ) core_top_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .imem_valid   (imem_valid),
      .imem_ready   (imem_ready),
      .imem_addr    (imem_addr),
      .imem_rvalid  (imem_rvalid),
      .imem_rready  (imem_rready),
      .imem_rdata   (imem_rdata),
      .wmem_valid   (wmem_valid),
      .wmem_ready   (wmem_ready),
      .wmem_addr    (wmem_addr),
      .wmem_data    (wmem_data),
      .commit_valid (commit_valid),
      .commit       (commit)
   );

   always #2 clk = ~clk;

   task automatic stop_run(input string what);
      $display("%s", what);
      $display("Simulation failed");
      $fatal(1, "run stopped on first error");
   endtask

   task automatic value_error(input string name, input word_t expected, input word_t actual);
      stop_run($sformatf("FAILED at %0t: %s expected %h, got %h",
                         $time, name, expected, actual));
   endtask

   // opcode, rd, rs1, rs2, 3 spare bits, imm
   function automatic word_t encode(input logic [3:0] op, input int rd, input int rs1,
                                    input int rs2, input int imm);
      return {op, rd[2:0], rs1[2:0], rs2[2:0], 3'b000, imm[15:0]};
   endfunction

   task automatic load_program();
      // independent writes, all from r0
      prog[0]  = encode(OP_ADDI, 1, 0, 0, 5);
      prog[1]  = encode(OP_ADDI, 2, 0, 0, 'h123);
      prog[2]  = encode(OP_ADDI, 3, 0, 0, -7);
      prog[3]  = encode(OP_ADDI, 4, 0, 0, 'h7fff);
      prog[4]  = encode(OP_XOR, 5, 2, 3, 0);
      // back to back dependent chain
      prog[5]  = encode(OP_ADDI, 6, 1, 0, 3);
      prog[6]  = encode(OP_ADD, 6, 6, 6, 0);
      prog[7]  = encode(OP_SUB, 7, 6, 1, 0);
      prog[8]  = encode(OP_AND, 7, 7, 3, 0);
      prog[9]  = encode(OP_OR, 7, 7, 2, 0);
      prog[10] = encode(OP_STORE, 0, 1, 7, 'h10);
      prog[11] = encode(OP_STORE, 0, 2, 6, -4);
      // skips the next two
      prog[12] = encode(OP_JUMP, 0, 0, 0, 2);
      prog[13] = encode(OP_ADDI, 1, 1, 0, 100);
      prog[14] = encode(OP_ADDI, 2, 2, 0, 100);
      prog[15] = encode(OP_ADDI, 5, 5, 0, 1);
      // jump to the very next word
      prog[16] = encode(OP_JUMP, 0, 0, 0, 0);
      prog[17] = encode(OP_STORE, 0, 0, 5, 'h40);
      prog[18] = encode(OP_XOR, 0, 0, 0, 0);
      prog[19] = encode(OP_JUMP, 0, 0, 0, 1);
      prog[20] = encode(OP_ADDI, 3, 3, 0, 1);
      prog[21] = encode(OP_STORE, 0, 4, 3, 8);
      prog[22] = encode(OP_NOP, 0, 0, 0, 0);
      // undefined opcode, retires like a nop
      prog[23] = encode(4'hf, 5, 1, 2, 'h55);
   endtask

   function automatic word_t fetch_word(input word_t addr);
      if (addr < word_t'(PROG_LEN * 4)) return prog[int'(addr >> 2)];
      return encode(OP_NOP, 0, 0, 0, 0);
   endfunction

   // only this word gets a slow response, the other jumps see normal latency
   function automatic logic slow_fetch(input word_t addr);
      return addr == word_t'(SLOW_WORD * 4);
   endfunction

   // in-order model of the instruction set, fills the expected queues
   function automatic void run_reference();
      word_t   regs [NUM_REGS];
      word_t   pc;
      word_t   next_pc;
      word_t   instr;
      word_t   a;
      word_t   b;
      word_t   imm_ext;
      commit_t c;
      store_t  s;
      int      steps;
      for (int i = 0; i < NUM_REGS; i++) begin
         regs[i] = '0;
      end
      pc    = RESET_PC;
      steps = 0;
      while (pc < word_t'(PROG_LEN * 4) && steps < 1000) begin
         instr       = prog[int'(pc >> 2)];
         a           = regs[instr[24:22]];
         b           = regs[instr[21:19]];
         imm_ext     = {{16{instr[15]}}, instr[15:0]};
         next_pc     = pc + 32'd4;
         c.pc        = pc;
         c.rd        = instr[27:25];
         c.result    = '0;
         c.writes_rd = instr[31:28] inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI};
         case (instr[31:28])
            OP_ADD:  c.result = a + b;
            OP_SUB:  c.result = a - b;
            OP_AND:  c.result = a & b;
            OP_OR:   c.result = a | b;
            OP_XOR:  c.result = a ^ b;
            OP_ADDI: c.result = a + imm_ext;
            OP_STORE: begin
               s.addr = a + imm_ext;
               s.data = b;
               exp_stores.push_back(s);
            end
            OP_JUMP: next_pc = pc + 32'd4 + (imm_ext << 2);
            default: ;
         endcase
         if (c.writes_rd) regs[c.rd] = c.result;
         exp_commits.push_back(c);
         pc = next_pc;
         steps++;
      end
   endfunction

   // instruction memory and data port, sampled on the edge, driven just after
   initial begin : memory_model
      logic  resp_pending;
      int    resp_wait;
      word_t resp_data;
      resp_pending = 1'b0;
      resp_wait    = 0;
      resp_data    = '0;
      imem_ready   = 1'b0;
      imem_rvalid  = 1'b0;
      imem_rdata   = '0;
      wmem_ready   = 1'b0;
      forever begin
         @(posedge clk);
         if (imem_rvalid && imem_rready) resp_pending = 1'b0;
         if (imem_valid && imem_ready) begin
            resp_pending = 1'b1;
            resp_data    = fetch_word(imem_addr);
            if (slow_fetch(imem_addr)) resp_wait = 7;
            else resp_wait = $random(seed) & 3;
         end else if (resp_pending && resp_wait > 0) begin
            resp_wait--;
         end
         #0.5;
         imem_ready  = (($random(seed) & 3) != 0);
         imem_rvalid = resp_pending && (resp_wait == 0);
         imem_rdata  = resp_data;
         wmem_ready  = (($random(seed) & 1) != 0);
      end
   end

   always @(posedge clk) begin : compare_outputs
      commit_t exp_c;
      store_t  exp_s;
      cycles++;
      if (commit_valid) begin
         assert (exp_commits.size() != 0)
            else stop_run($sformatf("unexpected commit at pc %h after the last instruction",
                                    commit.pc));
         exp_c = exp_commits.pop_front();
         assert (commit.pc == exp_c.pc) else value_error("commit.pc", exp_c.pc, commit.pc);
         assert (commit.writes_rd == exp_c.writes_rd)
            else value_error("commit.writes_rd", word_t'(exp_c.writes_rd),
                             word_t'(commit.writes_rd));
         if (exp_c.writes_rd) begin
            assert (commit.rd == exp_c.rd)
               else value_error("commit.rd", word_t'(exp_c.rd), word_t'(commit.rd));
            assert (commit.result == exp_c.result)
               else value_error("commit.result", exp_c.result, commit.result);
         end
      end
      if (wmem_valid && wmem_ready) begin
         assert (exp_stores.size() != 0)
            else stop_run($sformatf("unexpected store to %h", wmem_addr));
         exp_s = exp_stores.pop_front();
         assert (wmem_addr == exp_s.addr) else value_error("wmem_addr", exp_s.addr, wmem_addr);
         assert (wmem_data == exp_s.data) else value_error("wmem_data", exp_s.data, wmem_data);
      end
   end

   initial begin : run_test
      rst_n = 1'b0;
      load_program();
      run_reference();
      cycle_limit = 40 * exp_commits.size() + 100;
      repeat (3) @(posedge clk);
      #0.5;
      rst_n = 1'b1;
      // checked at the falling edge, away from the compare process
      while ((exp_commits.size() != 0 || exp_stores.size() != 0) && cycles < cycle_limit) begin
         @(negedge clk);
      end
      if (exp_commits.size() != 0 || exp_stores.size() != 0) begin
         stop_run($sformatf("timeout after %0d cycles, %0d commits and %0d stores never seen",
                            cycles, exp_commits.size(), exp_stores.size()));
      end else begin
         $display("Simulation passed");
         $finish;
      end
   end

endmodule

/* source/core_top.sv */
`timescale 1ns/100ps

module core_top
   import core_pkg::*;
#(
   parameter word_t RESET_PC = core_pkg::RESET_PC,
   parameter int    NUM_REGS = core_pkg::NUM_REGS
) (
   input  logic    clk,
   input  logic    rst_n,
   output logic    imem_valid,
   input  logic    imem_ready,
   output word_t   imem_addr,
   input  logic    imem_rvalid,
   output logic    imem_rready,
   input  word_t   imem_rdata,
   output logic    wmem_valid,
   input  logic    wmem_ready,
   output word_t   wmem_addr,
   output word_t   wmem_data,
   output logic    commit_valid,
   output commit_t commit
);

   fetch_item_t f_item;
   logic        f_valid;
   logic        f_ready;
   dec_item_t   d_item;
   logic        d_valid;
   logic        d_ready;
   exe_item_t   o_item;
   logic        o_valid;
   logic        o_ready;
   wb_item_t    e_item;
   logic        e_valid;
   logic        e_ready;

   // taken jump from execute, flushes everything younger
   logic        redirect_valid;
   word_t       redirect_pc;

   fetch_stage #(
      .RESET_PC (RESET_PC)
   ) fetch_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .redirect_valid (redirect_valid),
      .redirect_pc    (redirect_pc),
      .imem_valid     (imem_valid),
      .imem_ready     (imem_ready),
      .imem_addr      (imem_addr),
      .imem_rvalid    (imem_rvalid),
      .imem_rready    (imem_rready),
      .imem_rdata     (imem_rdata),
      .out_valid      (f_valid),
      .out_ready      (f_ready),
      .out_item       (f_item)
   );

   decode_stage decode_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .flush     (redirect_valid),
      .in_valid  (f_valid),
      .in_ready  (f_ready),
      .in_item   (f_item),
      .out_valid (d_valid),
      .out_ready (d_ready),
      .out_item  (d_item)
   );

   operand_stage #(
      .NUM_REGS (NUM_REGS)
   ) operand_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .flush        (redirect_valid),
      .in_valid     (d_valid),
      .in_ready     (d_ready),
      .in_item      (d_item),
      .out_valid    (o_valid),
      .out_ready    (o_ready),
      .out_item     (o_item),
      .commit_valid (commit_valid),
      .commit       (commit)
   );

   execute_stage execute_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .in_valid       (o_valid),
      .in_ready       (o_ready),
      .in_item        (o_item),
      .out_valid      (e_valid),
      .out_ready      (e_ready),
      .out_item       (e_item),
      .redirect_valid (redirect_valid),
      .redirect_pc    (redirect_pc)
   );

   writeback_stage writeback_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .in_valid     (e_valid),
      .in_ready     (e_ready),
      .in_item      (e_item),
      .wmem_valid   (wmem_valid),
      .wmem_ready   (wmem_ready),
      .wmem_addr    (wmem_addr),
      .wmem_data    (wmem_data),
      .commit_valid (commit_valid),
      .commit       (commit)
   );

endmodule

/* source/writeback_stage.sv */
`timescale 1ns/100ps

module writeback_stage
   import core_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     in_valid,
   output logic     in_ready,
   input  wb_item_t in_item,
   output logic     wmem_valid,
   input  logic     wmem_ready,
   output word_t    wmem_addr,
   output word_t    wmem_data,
   output logic     commit_valid,
   output commit_t  commit
);

   logic     held_valid;
   wb_item_t held;
   logic     take;

   assign wmem_valid = held_valid && held.is_store;
   assign wmem_addr  = held.store_addr;
   assign wmem_data  = held.result;

   // a store retires with its write handshake, anything else right away
   assign commit_valid = held_valid && (!held.is_store || wmem_ready);

   assign commit.pc        = held.pc;
   assign commit.rd        = held.rd;
   assign commit.result    = held.result;
   assign commit.writes_rd = held.writes_rd;

   assign in_ready = !held_valid || commit_valid;
   assign take     = in_valid && in_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         held_valid <= 1'b0;
      end else if (take) begin
         held_valid <= 1'b1;
      end else if (commit_valid) begin
         held_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (take) held <= in_item;
   end

endmodule

/* source/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage
   import core_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      in_valid,
   output logic      in_ready,
   input  exe_item_t in_item,
   output logic      out_valid,
   input  logic      out_ready,
   output wb_item_t  out_item,
   output logic      redirect_valid,
   output word_t     redirect_pc
);

   word_t    imm_ext;
   word_t    target;
   word_t    result;
   wb_item_t nxt;
   logic     out_is_jump;
   logic     take;

   // redirect fires as the jump leaves for writeback
   assign redirect_valid = out_valid && out_is_jump && out_ready;
   assign redirect_pc    = out_item.result;

   // the item offered by operand in the redirect cycle is younger, so it is refused
   assign in_ready = (!out_valid || out_ready) && !redirect_valid;
   assign take     = in_valid && in_ready;

   assign imm_ext = {{16{in_item.imm[15]}}, in_item.imm};
   assign target  = in_item.pc + 32'd4 + {imm_ext[29:0], 2'b00};

   always_comb begin
      case (in_item.opcode)
         OP_ADD:   result = in_item.rs1_val + in_item.rs2_val;
         OP_SUB:   result = in_item.rs1_val - in_item.rs2_val;
         OP_AND:   result = in_item.rs1_val & in_item.rs2_val;
         OP_OR:    result = in_item.rs1_val | in_item.rs2_val;
         OP_XOR:   result = in_item.rs1_val ^ in_item.rs2_val;
         OP_ADDI:  result = in_item.rs1_val + imm_ext;
         OP_STORE: result = in_item.rs2_val;
         OP_JUMP:  result = target;
         default:  result = '0;
      endcase
   end

   always_comb begin
      nxt.pc         = in_item.pc;
      nxt.rd         = in_item.rd;
      nxt.result     = result;
      nxt.store_addr = in_item.rs1_val + imm_ext;
      nxt.writes_rd  = in_item.writes_rd;
      nxt.is_store   = in_item.is_store;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid   <= 1'b0;
         out_is_jump <= 1'b0;
      end else if (take) begin
         out_valid   <= 1'b1;
         out_is_jump <= in_item.is_jump;
      end else if (out_ready) begin
         out_valid   <= 1'b0;
         out_is_jump <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (take) out_item <= nxt;
   end

endmodule

/* source/operand_stage.sv */
`timescale 1ns/100ps

module operand_stage
   import core_pkg::*;
#(
   parameter int NUM_REGS = core_pkg::NUM_REGS
) (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      flush,
   input  logic      in_valid,
   output logic      in_ready,
   input  dec_item_t in_item,
   output logic      out_valid,
   input  logic      out_ready,
   output exe_item_t out_item,
   input  logic      commit_valid,
   input  commit_t   commit
);

   word_t               regs [NUM_REGS];
   logic [NUM_REGS-1:0] pending;
   logic [NUM_REGS-1:0] set_mask;
   logic [NUM_REGS-1:0] clr_mask;
   logic                hazard;
   logic                take;
   exe_item_t           nxt;

   // rs1 is checked for every opcode, which only costs a cycle on nop and jump
   assign hazard = pending[in_item.rs1] ||
                   (in_item.reads_rs2 && pending[in_item.rs2]) ||
                   (in_item.writes_rd && pending[in_item.rd]);

   assign in_ready = (!out_valid || out_ready) && !hazard;
   assign take     = in_valid && in_ready && !flush;

   // rd must be clear to issue, so set and clear never hit the same bit
   always_comb begin
      set_mask = '0;
      clr_mask = '0;
      if (take && in_item.writes_rd) set_mask[in_item.rd] = 1'b1;
      if (commit_valid && commit.writes_rd) clr_mask[commit.rd] = 1'b1;
      // a flushed item never commits, so its rd is released here
      if (flush && out_valid && out_item.writes_rd) clr_mask[out_item.rd] = 1'b1;
   end

   always_comb begin
      nxt.pc        = in_item.pc;
      nxt.opcode    = in_item.opcode;
      nxt.rd        = in_item.rd;
      nxt.rs1_val   = regs[in_item.rs1];
      nxt.rs2_val   = regs[in_item.rs2];
      nxt.imm       = in_item.imm;
      nxt.writes_rd = in_item.writes_rd;
      nxt.is_store  = in_item.is_store;
      nxt.is_jump   = in_item.is_jump;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
         pending <= '0;
      end else begin
         pending <= (pending & ~clr_mask) | set_mask;
         // write lands at the end of the commit cycle
         if (commit_valid && commit.writes_rd) regs[commit.rd] <= commit.result;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else if (flush) begin
         out_valid <= 1'b0;
      end else if (take) begin
         out_valid <= 1'b1;
      end else if (out_ready) begin
         out_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (take) out_item <= nxt;
   end

endmodule

/* source/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage
   import core_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        flush,
   input  logic        in_valid,
   output logic        in_ready,
   input  fetch_item_t in_item,
   output logic        out_valid,
   input  logic        out_ready,
   output dec_item_t   out_item
);

   word_t     instr;
   dec_item_t dec;
   logic      take;

   assign instr    = in_item.instr;
   assign in_ready = !out_valid || out_ready;
   assign take     = in_valid && in_ready;

   always_comb begin
      dec.pc  = in_item.pc;
      dec.rd  = instr[RD_HI:RD_LO];
      dec.rs1 = instr[RS1_HI:RS1_LO];
      dec.rs2 = instr[RS2_HI:RS2_LO];
      dec.imm = instr[IMM_HI:IMM_LO];

      // undefined encodings fall back to nop
      case (instr[OPC_HI:OPC_LO])
         OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_STORE, OP_JUMP:
            dec.opcode = opcode_e'(instr[OPC_HI:OPC_LO]);
         default:
            dec.opcode = OP_NOP;
      endcase

      dec.writes_rd = dec.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI};
      // store data comes from rs2
      dec.reads_rs2 = dec.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_STORE};
      dec.is_store  = (dec.opcode == OP_STORE);
      dec.is_jump   = (dec.opcode == OP_JUMP);
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else if (flush) begin
         out_valid <= 1'b0;
      end else if (take) begin
         out_valid <= 1'b1;
      end else if (out_ready) begin
         out_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (take) out_item <= dec;
   end

endmodule

/* source/fetch_stage.sv */
`timescale 1ns/100ps

module fetch_stage
   import core_pkg::*;
#(
   parameter word_t RESET_PC = core_pkg::RESET_PC
) (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        redirect_valid,
   input  word_t       redirect_pc,
   output logic        imem_valid,
   input  logic        imem_ready,
   output word_t       imem_addr,
   input  logic        imem_rvalid,
   output logic        imem_rready,
   input  word_t       imem_rdata,
   output logic        out_valid,
   input  logic        out_ready,
   output fetch_item_t out_item
);

   typedef enum logic [1:0] {IDLE, WAIT_RESP, DROP} state_e;

   state_e state;
   word_t  pc;
   logic   run;
   logic   req_fire;
   logic   resp_fire;
   logic   push;

   // one request outstanding at most, pc stays on it until the word comes back
   assign imem_valid = run && (state == IDLE);
   assign imem_addr  = pc;

   // a stale response is always taken, a live one waits for room
   assign imem_rready = (state == DROP) ||
                        ((state == WAIT_RESP) && (!out_valid || out_ready));

   assign req_fire  = imem_valid && imem_ready;
   assign resp_fire = imem_rvalid && imem_rready;
   assign push      = resp_fire && (state == WAIT_RESP) && !redirect_valid;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= IDLE;
         pc        <= RESET_PC;
         run       <= 1'b0;
         out_valid <= 1'b0;
      end else begin
         run <= 1'b1;
         if (redirect_valid) begin
            pc        <= redirect_pc;
            out_valid <= 1'b0;
         end else if (push) begin
            pc        <= pc + 32'd4;
            out_valid <= 1'b1;
         end else if (out_ready) begin
            out_valid <= 1'b0;
         end

         case (state)
            IDLE: begin
               // a request sent in the redirect cycle belongs to the old path
               if (req_fire) state <= redirect_valid ? DROP : WAIT_RESP;
            end
            WAIT_RESP: begin
               if (resp_fire) state <= IDLE;
               else if (redirect_valid) state <= DROP;
            end
            DROP: begin
               if (resp_fire) state <= IDLE;
            end
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         out_item.pc    <= pc;
         out_item.instr <= imem_rdata;
      end
   end

endmodule

/* source/core_pkg.sv */
package core_pkg;

   typedef logic [31:0] word_t;
   typedef logic [2:0]  reg_idx_t;
   typedef logic [15:0] imm_t;

   typedef enum logic [3:0] {
      OP_NOP   = 4'h0,
      OP_ADD   = 4'h1,
      OP_SUB   = 4'h2,
      OP_AND   = 4'h3,
      OP_OR    = 4'h4,
      OP_XOR   = 4'h5,
      OP_ADDI  = 4'h6,
      OP_STORE = 4'h7,
      OP_JUMP  = 4'h8
   } opcode_e;

   // instruction word layout
   localparam int OPC_HI = 31;
   localparam int OPC_LO = 28;
   localparam int RD_HI  = 27;
   localparam int RD_LO  = 25;
   localparam int RS1_HI = 24;
   localparam int RS1_LO = 22;
   localparam int RS2_HI = 21;
   localparam int RS2_LO = 19;
   localparam int IMM_HI = 15;
   localparam int IMM_LO = 0;

   localparam int    NUM_REGS = 8;
   localparam word_t RESET_PC = 32'h0000_0000;

   typedef struct packed {
      word_t pc;
      word_t instr;
   } fetch_item_t;

   typedef struct packed {
      word_t    pc;
      opcode_e  opcode;
      reg_idx_t rd;
      reg_idx_t rs1;
      reg_idx_t rs2;
      imm_t     imm;
      logic     writes_rd;
      logic     reads_rs2;
      logic     is_store;
      logic     is_jump;
   } dec_item_t;

   typedef struct packed {
      word_t    pc;
      opcode_e  opcode;
      reg_idx_t rd;
      word_t    rs1_val;
      word_t    rs2_val;
      imm_t     imm;
      logic     writes_rd;
      logic     is_store;
      logic     is_jump;
   } exe_item_t;

   // result holds the store data for a store and the target for a jump
   typedef struct packed {
      word_t    pc;
      reg_idx_t rd;
      word_t    result;
      word_t    store_addr;
      logic     writes_rd;
      logic     is_store;
   } wb_item_t;

   typedef struct packed {
      word_t    pc;
      reg_idx_t rd;
      word_t    result;
      logic     writes_rd;
   } commit_t;

endpackage
